// File: hdl/rv_decode_pkg.sv
/*
 * shared RV64I decode types, base opcodes only
 * no RV64M, MISC_MEM and SYSTEM are recognized but not decoded further
 */

`default_nettype none

package rv_decode_pkg;

    // datapath widths
    localparam int xlen          = 64;
    localparam int inst_width    = 32;
    localparam int reg_idx_width = 5;

    // base opcodes, RISC-V encodings
    typedef enum logic [6:0] {
        OP_LUI      = 7'b0110111,
        OP_AUIPC    = 7'b0010111,
        OP_JAL      = 7'b1101111,
        OP_JALR     = 7'b1100111,
        OP_BRANCH   = 7'b1100011,
        OP_LOAD     = 7'b0000011,
        OP_STORE    = 7'b0100011,
        OP_OP_IMM   = 7'b0010011,
        OP_IMM_32   = 7'b0011011,
        OP_OP       = 7'b0110011,
        OP_OP_32    = 7'b0111011,
        OP_MISC_MEM = 7'b0001111,
        OP_SYSTEM   = 7'b1110011
    } opcode_t;

    // alu operation codes, same as OP/OP_IMM funct3
    typedef enum logic [2:0] {
        F3OP_ADD_SUB = 3'b000,
        F3OP_SLL     = 3'b001,
        F3OP_SLT     = 3'b010,
        F3OP_SLTU    = 3'b011,
        F3OP_XOR     = 3'b100,
        F3OP_SRX     = 3'b101,
        F3OP_OR      = 3'b110,
        F3OP_AND     = 3'b111
    } f3_op_t;

    // branch funct3, 010 and 011 are not defined
    typedef enum logic [2:0] {
        F3B_BEQ  = 3'b000,
        F3B_BNE  = 3'b001,
        F3B_BLT  = 3'b100,
        F3B_BGE  = 3'b101,
        F3B_BLTU = 3'b110,
        F3B_BGEU = 3'b111
    } f3_branch_t;

    // funct7 that turns add into sub
    localparam logic [6:0] funct7_sub = 7'b0100000;

    // when the execute stage takes the jump
    typedef enum logic [1:0] {
        JUMP_NO, JUMP_YES, JUMP_ALU_EQZ, JUMP_ALU_NEZ
    } jump_code_t;

    // immediate layout select
    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_t;

    // instruction word views, fields msb first
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [reg_idx_width-1:0] rs2, rs1;
            logic [2:0] funct3;
            logic [reg_idx_width-1:0] rd;
            opcode_t opcode;
        } r_type;
        struct packed {
            logic [11:0] imm_11_0;
            logic [reg_idx_width-1:0] rs1;
            logic [2:0] funct3;
            logic [reg_idx_width-1:0] rd;
            opcode_t opcode;
        } i_type;
        struct packed {
            logic [6:0] imm_11_5;
            logic [reg_idx_width-1:0] rs2, rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            opcode_t opcode;
        } s_type;
        struct packed {
            logic imm_12;
            logic [5:0] imm_10_5;
            logic [reg_idx_width-1:0] rs2, rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic imm_11;
            opcode_t opcode;
        } b_type;
        struct packed {
            logic [19:0] imm_31_12;
            logic [reg_idx_width-1:0] rd;
            opcode_t opcode;
        } u_type;
        struct packed {
            logic imm_20;
            logic [9:0] imm_10_1;
            logic imm_11;
            logic [7:0] imm_19_12;
            logic [reg_idx_width-1:0] rd;
            opcode_t opcode;
        } j_type;
    } rv_inst_u;

endpackage

`default_nettype wire

// File: hdl/decode_ctrl_if.sv
/*
 * decoded control fields, decoder to stage register
 * purely combinational bundle, no clock inside
 */

`timescale 1ns/100ps
`default_nettype none

interface decode_ctrl_if;
    import rv_decode_pkg::*;

    // register indices and their enables
    logic [reg_idx_width-1:0] rs1, rs2, rd;
    logic en_rs1, en_rs2, en_rd;
    // alu controls
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic alu_use_immed, alu_width_32, keep_pc_plus_immed;
    // jump controls
    jump_code_t jump_if;
    logic jump_absolute;
    logic illegal;

    modport src (output rs1, rs2, rd, en_rs1, en_rs2, en_rd, funct3, funct7,
                 alu_use_immed, alu_width_32, keep_pc_plus_immed,
                 jump_if, jump_absolute, illegal);

    modport dst (input rs1, rs2, rd, en_rs1, en_rs2, en_rd, funct3, funct7,
                 alu_use_immed, alu_width_32, keep_pc_plus_immed,
                 jump_if, jump_absolute, illegal);
endinterface

`default_nettype wire

// File: hdl/imm_gen.sv
/*
 * immediate builder, combinational
 * all formats sign-extended from inst[31], IMM_NONE gives zero
 */

`timescale 1ns/100ps
`default_nettype none

module imm_gen (
    input  rv_decode_pkg::rv_inst_u            inst,
    input  rv_decode_pkg::imm_fmt_t            imm_fmt,
    output logic [rv_decode_pkg::xlen-1:0]     imm
);
    import rv_decode_pkg::*;

    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    // 12 bit, straight field
    assign imm_i = {{(xlen-12){inst.i_type.imm_11_0[11]}}, inst.i_type.imm_11_0};

    // split around rd position
    assign imm_s = {{(xlen-12){inst.s_type.imm_11_5[6]}},
                    inst.s_type.imm_11_5, inst.s_type.imm_4_0};

    // 13 bit, halfword aligned
    assign imm_b = {{(xlen-13){inst.b_type.imm_12}}, inst.b_type.imm_12,
                    inst.b_type.imm_11, inst.b_type.imm_10_5,
                    inst.b_type.imm_4_1, 1'b0};

    // upper 20, low 12 zero
    assign imm_u = {{(xlen-32){inst.u_type.imm_31_12[19]}},
                    inst.u_type.imm_31_12, 12'b0};

    // 21 bit, scrambled jal layout
    assign imm_j = {{(xlen-21){inst.j_type.imm_20}}, inst.j_type.imm_20,
                    inst.j_type.imm_19_12, inst.j_type.imm_11,
                    inst.j_type.imm_10_1, 1'b0};

    always_comb begin
        case (imm_fmt)
            IMM_I:   imm = imm_i;
            IMM_S:   imm = imm_s;
            IMM_B:   imm = imm_b;
            IMM_U:   imm = imm_u;
            IMM_J:   imm = imm_j;
            default: imm = '0;
        endcase
    end
endmodule

`default_nettype wire

// File: hdl/decode_ctrl.sv
/*
 * RV64I opcode table, combinational
 * unknown opcodes and branch funct3 010/011 flag illegal
 * MISC_MEM and SYSTEM only decode to "no operands"
 */

`timescale 1ns/100ps
`default_nettype none

module decode_ctrl (
    input  rv_decode_pkg::rv_inst_u  inst,
    output rv_decode_pkg::imm_fmt_t  imm_fmt,
    decode_ctrl_if.src               ctl
);
    import rv_decode_pkg::*;

    // used registers as {rs1, rs2, rd}
    logic [2:0] used;
    logic [reg_idx_width-1:0] rs1_idx;
    f3_branch_t br_f3;

    assign br_f3 = f3_branch_t'(inst.b_type.funct3);

    always_comb begin
        // defaults, overridden per opcode below
        rs1_idx                = inst.r_type.rs1;
        used                   = 3'b000;
        imm_fmt                = IMM_NONE;
        ctl.funct3             = inst.r_type.funct3;
        ctl.funct7             = inst.r_type.funct7;
        ctl.alu_use_immed      = 1'b0;
        ctl.alu_width_32       = 1'b0;
        ctl.keep_pc_plus_immed = 1'b0;
        ctl.jump_if            = JUMP_NO;
        ctl.jump_absolute      = 1'b0;
        ctl.illegal            = 1'b0;

        case (inst.r_type.opcode)
            OP_LUI, OP_AUIPC: begin
                // alu computes 0 + imm
                imm_fmt           = IMM_U;
                rs1_idx           = '0;
                used              = 3'b001;
                ctl.funct3        = F3OP_ADD_SUB;
                ctl.funct7        = '0;
                ctl.alu_use_immed = 1'b1;
                // pc adder result replaces alu result
                ctl.keep_pc_plus_immed = (inst.r_type.opcode == OP_AUIPC);
            end
            OP_JAL: begin
                imm_fmt           = IMM_J;
                rs1_idx           = '0;
                used              = 3'b001;
                ctl.funct3        = F3OP_ADD_SUB;
                ctl.funct7        = '0;
                ctl.alu_use_immed = 1'b1;
                // pc relative target
                ctl.jump_if       = JUMP_YES;
            end
            OP_JALR: begin
                imm_fmt           = IMM_I;
                used              = 3'b101;
                ctl.funct3        = F3OP_ADD_SUB;
                ctl.funct7        = '0;
                ctl.alu_use_immed = 1'b1;
                // target is rs1 + imm from alu
                ctl.jump_if       = JUMP_YES;
                ctl.jump_absolute = 1'b1;
            end
            OP_BRANCH: begin
                imm_fmt    = IMM_B;
                used       = 3'b110;
                ctl.funct7 = '0;
                // alu compares rs1 with rs2, jump tests the result
                case (br_f3)
                    F3B_BEQ, F3B_BNE: begin
                        ctl.funct3  = F3OP_ADD_SUB;
                        ctl.funct7  = funct7_sub;
                        ctl.jump_if = (br_f3 == F3B_BEQ) ? JUMP_ALU_EQZ : JUMP_ALU_NEZ;
                    end
                    F3B_BLT, F3B_BGE: begin
                        ctl.funct3  = F3OP_SLT;
                        ctl.jump_if = (br_f3 == F3B_BLT) ? JUMP_ALU_NEZ : JUMP_ALU_EQZ;
                    end
                    F3B_BLTU, F3B_BGEU: begin
                        ctl.funct3  = F3OP_SLTU;
                        ctl.jump_if = (br_f3 == F3B_BLTU) ? JUMP_ALU_NEZ : JUMP_ALU_EQZ;
                    end
                    default: ctl.illegal = 1'b1;
                endcase
            end
            OP_LOAD, OP_STORE: begin
                // alu forms the address rs1 + imm
                imm_fmt           = (inst.r_type.opcode == OP_LOAD) ? IMM_I : IMM_S;
                used              = (inst.r_type.opcode == OP_LOAD) ? 3'b101 : 3'b110;
                ctl.funct3        = F3OP_ADD_SUB;
                ctl.funct7        = '0;
                ctl.alu_use_immed = 1'b1;
            end
            OP_OP_IMM, OP_IMM_32: begin
                // funct7 kept, it selects srai
                imm_fmt           = IMM_I;
                used              = 3'b101;
                ctl.alu_use_immed = 1'b1;
                ctl.alu_width_32  = (inst.r_type.opcode == OP_IMM_32);
            end
            OP_OP, OP_OP_32: begin
                used             = 3'b111;
                ctl.alu_width_32 = (inst.r_type.opcode == OP_OP_32);
            end
            OP_MISC_MEM, OP_SYSTEM: begin
                ctl.funct7 = '0;
            end
            default: ctl.illegal = 1'b1;
        endcase

        // illegal leaves nothing active downstream
        if (ctl.illegal) begin
            used                   = 3'b000;
            imm_fmt                = IMM_NONE;
            ctl.alu_use_immed      = 1'b0;
            ctl.alu_width_32       = 1'b0;
            ctl.keep_pc_plus_immed = 1'b0;
            ctl.jump_if            = JUMP_NO;
            ctl.jump_absolute      = 1'b0;
        end

        ctl.rs1 = rs1_idx;
        ctl.rs2 = inst.r_type.rs2;
        ctl.rd  = inst.r_type.rd;
        // x0 never needs hazard checks or writeback
        ctl.en_rs1 = used[2] && (rs1_idx != '0);
        ctl.en_rs2 = used[1] && (inst.r_type.rs2 != '0);
        ctl.en_rd  = used[0] && (inst.r_type.rd != '0);
    end
endmodule

`default_nettype wire

// File: hdl/decode_out_reg.sv
/*
 * decode stage register, one word per cycle, no back-pressure
 * reset clears valid and control, payload holds while inst_valid is low
 */

`timescale 1ns/100ps
`default_nettype none

module decode_out_reg (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   inst_valid,
    input  logic [rv_decode_pkg::xlen-1:0]         imm,
    decode_ctrl_if.dst                             ctl,
    output logic                                   out_valid,
    output logic [rv_decode_pkg::xlen-1:0]         imm_q,
    output logic [rv_decode_pkg::reg_idx_width-1:0] rs1, rs2, rd,
    output logic                                   en_rs1, en_rs2, en_rd,
    output logic [2:0]                             funct3,
    output logic [6:0]                             funct7,
    output logic                                   alu_use_immed, alu_width_32,
    output logic                                   keep_pc_plus_immed,
    output rv_decode_pkg::jump_code_t              jump_if,
    output logic                                   jump_absolute,
    output logic                                   illegal
);
    import rv_decode_pkg::*;

    // control, cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid          <= 1'b0;
            {en_rs1, en_rs2, en_rd} <= 3'b000;
            alu_use_immed      <= 1'b0;
            alu_width_32       <= 1'b0;
            keep_pc_plus_immed <= 1'b0;
            jump_if            <= JUMP_NO;
            jump_absolute      <= 1'b0;
            illegal            <= 1'b0;
        end else begin
            out_valid <= inst_valid;
            if (inst_valid) begin
                {en_rs1, en_rs2, en_rd} <= {ctl.en_rs1, ctl.en_rs2, ctl.en_rd};
                alu_use_immed      <= ctl.alu_use_immed;
                alu_width_32       <= ctl.alu_width_32;
                keep_pc_plus_immed <= ctl.keep_pc_plus_immed;
                jump_if            <= ctl.jump_if;
                jump_absolute      <= ctl.jump_absolute;
                illegal            <= ctl.illegal;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            imm_q  <= imm;
            rs1    <= ctl.rs1;
            rs2    <= ctl.rs2;
            rd     <= ctl.rd;
            funct3 <= ctl.funct3;
            funct7 <= ctl.funct7;
        end
    end
endmodule

`default_nettype wire

// File: hdl/rv_decoder.sv
/*
 * RV64I decode stage top, one cycle latency
 * every valid word is accepted, no ready
 */

`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   inst_valid,
    input  logic [rv_decode_pkg::inst_width-1:0]   inst,
    output logic                                   out_valid,
    output logic [rv_decode_pkg::xlen-1:0]         imm,
    output logic [rv_decode_pkg::reg_idx_width-1:0] rs1, rs2, rd,
    output logic                                   en_rs1, en_rs2, en_rd,
    output logic [2:0]                             funct3,
    output logic [6:0]                             funct7,
    output logic                                   alu_use_immed, alu_width_32,
    output logic                                   keep_pc_plus_immed,
    output rv_decode_pkg::jump_code_t              jump_if,
    output logic                                   jump_absolute,
    output logic                                   illegal
);
    import rv_decode_pkg::*;

    imm_fmt_t        imm_fmt;
    logic [xlen-1:0] imm_comb;

    decode_ctrl_if ctl_bus ();

    // opcode table
    decode_ctrl u_ctrl (
        .inst    (rv_inst_u'(inst)),
        .imm_fmt (imm_fmt),
        .ctl     (ctl_bus.src)
    );

    // immediate from format chosen above
    imm_gen u_imm (
        .inst    (rv_inst_u'(inst)),
        .imm_fmt (imm_fmt),
        .imm     (imm_comb)
    );

    decode_out_reg u_reg (
        .clk                (clk),
        .reset              (reset),
        .inst_valid         (inst_valid),
        .imm                (imm_comb),
        .ctl                (ctl_bus.dst),
        .out_valid          (out_valid),
        .imm_q              (imm),
        .rs1                (rs1),
        .rs2                (rs2),
        .rd                 (rd),
        .en_rs1             (en_rs1),
        .en_rs2             (en_rs2),
        .en_rd              (en_rd),
        .funct3             (funct3),
        .funct7             (funct7),
        .alu_use_immed      (alu_use_immed),
        .alu_width_32       (alu_width_32),
        .keep_pc_plus_immed (keep_pc_plus_immed),
        .jump_if            (jump_if),
        .jump_absolute      (jump_absolute),
        .illegal            (illegal)
    );
endmodule

`default_nettype wire

// File: tb/rv_decoder_checker.sv
/*
 * protocol assertions, bound into rv_decoder
 * needs assertions enabled in the simulator
 */

`timescale 1ns/100ps
`default_nettype none

module rv_decoder_checker (
    input logic                       clk,
    input logic                       reset,
    input logic                       inst_valid,
    input logic                       out_valid,
    input logic                       en_rs1,
    input logic                       en_rs2,
    input logic                       en_rd,
    input logic                       illegal,
    input rv_decode_pkg::jump_code_t  jump_if
);
    import rv_decode_pkg::*;

    // first cycle out of reset
    reset_clears_valid: assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high in the cycle after reset");

    // illegal words leave nothing active
    illegal_is_quiet: assert property (@(posedge clk) disable iff (reset)
        illegal |-> (!en_rs1 && !en_rs2 && !en_rd && jump_if == JUMP_NO))
        else $error("illegal instruction with an enable set or a jump pending");

    // single stage, one cycle delay
    valid_follows_input: assert property (@(posedge clk)
        !reset |=> (out_valid == $past(inst_valid)))
        else $error("out_valid does not follow inst_valid by one cycle");
endmodule

`default_nettype wire

// File: tb/tb_rv_decoder.sv
/*
 * random-stimulus testbench for the decode stage, fixed LCG seed
 * outputs sampled at the falling edge, checked against a model of the decode table
 * payload fields are only compared once a valid word has been loaded
 */

`timescale 1ns/100ps
`default_nettype none

module tb_rv_decoder;
    import rv_decode_pkg::*;

    localparam int clk_period   = 8;
    localparam int reset_cycles = 10;
    localparam int num_words    = 2000;
    localparam int watchdog_ns  = (num_words + reset_cycles + 20) * clk_period;
    localparam logic [31:0] lcg_seed = 32'hd634;

    // expected contents of the stage register
    typedef struct packed {
        logic [xlen-1:0]          imm;
        logic [reg_idx_width-1:0] rs1;
        logic [reg_idx_width-1:0] rs2;
        logic [reg_idx_width-1:0] rd;
        logic                     en_rs1;
        logic                     en_rs2;
        logic                     en_rd;
        logic [2:0]               funct3;
        logic [6:0]               funct7;
        logic                     alu_use_immed;
        logic                     alu_width_32;
        logic                     keep_pc_plus_immed;
        jump_code_t               jump_if;
        logic                     jump_absolute;
        logic                     illegal;
    } decode_exp_t;

    logic                     clk;
    logic                     reset;
    logic                     inst_valid;
    logic [inst_width-1:0]    inst;
    logic                     out_valid;
    logic [xlen-1:0]          imm;
    logic [reg_idx_width-1:0] rs1, rs2, rd;
    logic                     en_rs1, en_rs2, en_rd;
    logic [2:0]               funct3;
    logic [6:0]               funct7;
    logic                     alu_use_immed, alu_width_32, keep_pc_plus_immed;
    jump_code_t               jump_if;
    logic                     jump_absolute;
    logic                     illegal;

    logic [31:0]  lcg_state;
    // one entry in flight between drive and check
    logic         valid_q[$];
    decode_exp_t  exp_q[$];

    rv_decoder uut (
        .clk                (clk),
        .reset              (reset),
        .inst_valid         (inst_valid),
        .inst               (inst),
        .out_valid          (out_valid),
        .imm                (imm),
        .rs1                (rs1),
        .rs2                (rs2),
        .rd                 (rd),
        .en_rs1             (en_rs1),
        .en_rs2             (en_rs2),
        .en_rd              (en_rd),
        .funct3             (funct3),
        .funct7             (funct7),
        .alu_use_immed      (alu_use_immed),
        .alu_width_32       (alu_width_32),
        .keep_pc_plus_immed (keep_pc_plus_immed),
        .jump_if            (jump_if),
        .jump_absolute      (jump_absolute),
        .illegal            (illegal)
    );

    bind rv_decoder rv_decoder_checker u_checker (
        .clk        (clk),
        .reset      (reset),
        .inst_valid (inst_valid),
        .out_valid  (out_valid),
        .en_rs1     (en_rs1),
        .en_rs2     (en_rs2),
        .en_rd      (en_rd),
        .illegal    (illegal),
        .jump_if    (jump_if)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("CHECKS FAILED");
        $fatal(1, "%s", why);
    endtask

    initial begin : watchdog
        #(watchdog_ns);
        $display("watchdog expired, the test sequence did not finish in time");
        abort_run("timeout");
    end

    // numerical recipes constants
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic opcode_t legal_opcode(int idx);
        case (idx)
            0:       return OP_LUI;
            1:       return OP_AUIPC;
            2:       return OP_JAL;
            3:       return OP_JALR;
            4:       return OP_BRANCH;
            5:       return OP_LOAD;
            6:       return OP_STORE;
            7:       return OP_OP_IMM;
            8:       return OP_IMM_32;
            9:       return OP_OP;
            10:      return OP_OP_32;
            11:      return OP_MISC_MEM;
            default: return OP_SYSTEM;
        endcase
    endfunction

    function automatic logic [31:0] make_word();
        logic [31:0] mix;
        logic [31:0] w;
        mix = lcg_next();
        w   = lcg_next();
        // about one in eight fully random, mostly unknown opcodes
        if (mix[31:28] < 4'd2)
            return w;
        w[6:0] = legal_opcode(int'(mix[7:0]) % 13);
        // some words with register fields cleared to reach x0
        if (mix[31:28] < 4'd5) begin
            if (mix[16])
                w[19:15] = '0;
            if (mix[17])
                w[24:20] = '0;
            if (mix[18])
                w[11:7] = '0;
        end
        return w;
    endfunction

    // reference decode, straight from the opcode table
    function automatic decode_exp_t model_decode(logic [31:0] w);
        decode_exp_t e;
        logic [2:0]  used;
        e        = '0;
        used     = 3'b000;
        e.rs1    = w[19:15];
        e.rs2    = w[24:20];
        e.rd     = w[11:7];
        e.funct3 = w[14:12];
        e.funct7 = w[31:25];
        case (w[6:0])
            OP_LUI, OP_AUIPC: begin
                e.imm = {{32{w[31]}}, w[31:12], 12'h000};
                e.rs1 = '0;
                used  = 3'b001;
                e.funct3 = 3'b000;
                e.funct7 = '0;
                e.alu_use_immed = 1'b1;
                e.keep_pc_plus_immed = (w[6:0] == OP_AUIPC);
            end
            OP_JAL: begin
                e.imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
                e.rs1 = '0;
                used  = 3'b001;
                e.funct3 = 3'b000;
                e.funct7 = '0;
                e.alu_use_immed = 1'b1;
                e.jump_if = JUMP_YES;
            end
            OP_JALR, OP_LOAD: begin
                e.imm = {{52{w[31]}}, w[31:20]};
                used  = 3'b101;
                e.funct3 = 3'b000;
                e.funct7 = '0;
                e.alu_use_immed = 1'b1;
                e.jump_if = (w[6:0] == OP_JALR) ? JUMP_YES : JUMP_NO;
                e.jump_absolute = (w[6:0] == OP_JALR);
            end
            OP_STORE: begin
                e.imm = {{52{w[31]}}, w[31:25], w[11:7]};
                used  = 3'b110;
                e.funct3 = 3'b000;
                e.funct7 = '0;
                e.alu_use_immed = 1'b1;
            end
            OP_BRANCH: begin
                e.imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                used  = 3'b110;
                e.funct7 = '0;
                case (w[14:12])
                    3'b000, 3'b001: begin
                        e.funct3  = 3'b000;
                        e.funct7  = 7'b0100000;
                        e.jump_if = w[12] ? JUMP_ALU_NEZ : JUMP_ALU_EQZ;
                    end
                    3'b100, 3'b110: begin
                        e.funct3  = {2'b01, w[13]};
                        e.jump_if = JUMP_ALU_NEZ;
                    end
                    3'b101, 3'b111: begin
                        e.funct3  = {2'b01, w[13]};
                        e.jump_if = JUMP_ALU_EQZ;
                    end
                    default: e.illegal = 1'b1;
                endcase
            end
            OP_OP_IMM, OP_IMM_32: begin
                e.imm = {{52{w[31]}}, w[31:20]};
                used  = 3'b101;
                e.alu_use_immed = 1'b1;
                e.alu_width_32  = (w[6:0] == OP_IMM_32);
            end
            OP_OP, OP_OP_32: begin
                used = 3'b111;
                e.alu_width_32 = (w[6:0] == OP_OP_32);
            end
            OP_MISC_MEM, OP_SYSTEM: e.funct7 = '0;
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal) begin
            e.imm  = '0;
            used   = 3'b000;
            e.alu_use_immed      = 1'b0;
            e.keep_pc_plus_immed = 1'b0;
            e.jump_if            = JUMP_NO;
        end
        e.en_rs1 = used[2] && (e.rs1 != '0);
        e.en_rs2 = used[1] && (e.rs2 != '0);
        e.en_rd  = used[0] && (e.rd != '0);
        return e;
    endfunction

    task automatic check_imm(string name, logic [xlen-1:0] exp, logic [xlen-1:0] act);
        if (act !== exp) begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            abort_run("immediate mismatch");
        end
    endtask

    task automatic check_reg(string name, logic [reg_idx_width-1:0] exp_idx,
                             logic [reg_idx_width-1:0] act_idx, logic exp_en, logic act_en);
        if (act_idx !== exp_idx || act_en !== exp_en) begin
            $display("** Error %s: expected idx %0d en %b, actual idx %0d en %b",
                     name, exp_idx, exp_en, act_idx, act_en);
            abort_run("register field mismatch");
        end
    endtask

    task automatic check_jump(string name, jump_code_t exp, jump_code_t act);
        if (act !== exp) begin
            $display("** Error %s: expected %s, actual %s (%b)",
                     name, exp.name(), act.name(), act);
            abort_run("jump condition mismatch");
        end
    endtask

    task automatic check_alu(string name, logic [2:0] exp_f3, logic [2:0] act_f3,
                             logic [6:0] exp_f7, logic [6:0] act_f7);
        if (act_f3 !== exp_f3 || act_f7 !== exp_f7) begin
            $display("** Error %s: expected funct3 %b funct7 %b, actual funct3 %b funct7 %b",
                     name, exp_f3, exp_f7, act_f3, act_f7);
            abort_run("alu code mismatch");
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("** Error %s: expected %b, actual %b", name, exp, act);
            abort_run("flag mismatch");
        end
    endtask

    task automatic check_outputs(string tag, logic exp_valid, decode_exp_t e, logic loaded);
        check_flag({tag, " out_valid"}, exp_valid, out_valid);
        if (loaded) begin
            check_imm({tag, " imm"}, e.imm, imm);
            check_reg({tag, " rs1"}, e.rs1, rs1, e.en_rs1, en_rs1);
            check_reg({tag, " rs2"}, e.rs2, rs2, e.en_rs2, en_rs2);
            check_reg({tag, " rd"}, e.rd, rd, e.en_rd, en_rd);
            check_alu({tag, " alu codes"}, e.funct3, funct3, e.funct7, funct7);
        end else begin
            // indices undefined until the first load
            check_flag({tag, " en_rs1"}, e.en_rs1, en_rs1);
            check_flag({tag, " en_rs2"}, e.en_rs2, en_rs2);
            check_flag({tag, " en_rd"}, e.en_rd, en_rd);
        end
        check_flag({tag, " alu_use_immed"}, e.alu_use_immed, alu_use_immed);
        check_flag({tag, " alu_width_32"}, e.alu_width_32, alu_width_32);
        check_flag({tag, " keep_pc_plus_immed"}, e.keep_pc_plus_immed, keep_pc_plus_immed);
        check_flag({tag, " jump_absolute"}, e.jump_absolute, jump_absolute);
        check_flag({tag, " illegal"}, e.illegal, illegal);
        check_jump({tag, " jump_if"}, e.jump_if, jump_if);
    endtask

    initial begin : stimulus
        logic [31:0] word;
        logic [31:0] r;
        logic        valid;
        logic        exp_valid;
        logic        loaded;
        decode_exp_t cur;
        decode_exp_t next;
        int          n;
        lcg_state  = lcg_seed;
        reset      = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        cur        = '0;
        loaded     = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        // nothing valid yet, stage stays in its reset state
        repeat (3) begin
            @(negedge clk);
            check_outputs("after reset", 1'b0, cur, 1'b0);
        end
        // the idle cycle already sampled
        valid_q.push_back(1'b0);
        exp_q.push_back(cur);
        for (n = 0; n <= num_words; n++) begin
            @(posedge clk);
            word  = '0;
            valid = 1'b0;
            if (n < num_words) begin
                word  = make_word();
                r     = lcg_next();
                valid = (r[31:30] != 2'b00);
            end
            inst_valid <= valid;
            inst       <= word;
            valid_q.push_back(valid);
            exp_q.push_back(model_decode(word));
            // outputs now hold the word sampled at this edge
            @(negedge clk);
            exp_valid = valid_q.pop_front();
            next      = exp_q.pop_front();
            if (exp_valid) begin
                cur    = next;
                loaded = 1'b1;
            end
            check_outputs($sformatf("cycle %0d", n), exp_valid, cur, loaded);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end
endmodule

`default_nettype wire

// File: list.f
hdl/rv_decode_pkg.sv
hdl/decode_ctrl_if.sv
hdl/imm_gen.sv
hdl/decode_ctrl.sv
hdl/decode_out_reg.sv
hdl/rv_decoder.sv
tb/rv_decoder_checker.sv
tb/tb_rv_decoder.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_rv_decoder
FILELIST  = list.f
OBJDIR    = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
